//--- vlog.f
source/bus_pkg.sv
source/prefetch_pkg.sv
source/fetch_unit.sv
source/prefetch_fifo.sv
source/prefetch_top.sv
tests/prefetch_assertions.sv
tests/prefetch_tb.sv

//--- Makefile
SRCS := $(wildcard source/*.sv tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/prefetch_sim: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module prefetch_tb \
		--Mdir obj_dir -o prefetch_sim -f vlog.f

run: obj_dir/prefetch_sim
	./obj_dir/prefetch_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/prefetch_tb.sv
// Testbench for the fetch front end, with a bus memory model, redirects and byte stream checks
`timescale 1ns/1ps

module prefetch_tb;
    import bus_pkg::*;
    import prefetch_pkg::*;

    localparam int unsigned fifo_depth = 6;
    localparam int unsigned n_reads = 1500;
    // Random reads plus the directed phases
    localparam int unsigned planned_reads = n_reads + 250;
    localparam int unsigned clk_period = 20;

    logic       clk;
    logic       arst_n;
    logic       load_new_ip;
    seg_t       new_cs;
    offset_t    new_ip;
    logic       rd_en;
    byte_t      rd_data;
    logic       empty;
    logic       mem_access;
    word_addr_t mem_address;
    logic       mem_ack;
    word_t      mem_data;

    logic [31:0] lfsr;
    seg_t        exp_cs;
    offset_t     exp_ip;
    logic        flush_cycle;
    logic        mem_busy;
    logic [1:0]  wait_left;
    logic        hold_ack;
    logic        access_pending;
    int unsigned pops;
    int unsigned byte_errors;
    int unsigned other_errors;

    prefetch_top #(
        .fifo_depth (fifo_depth)
    ) dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .load_new_ip (load_new_ip),
        .new_cs      (new_cs),
        .new_ip      (new_ip),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .empty       (empty),
        .mem_access  (mem_access),
        .mem_address (mem_address),
        .mem_ack     (mem_ack),
        .mem_data    (mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int unsigned n);
        logic [31:0] bits;
        logic        out;
        bits = '0;
        for (int unsigned i = 0; i < n; i++) begin
            out = lfsr[0];
            lfsr = lfsr >> 1;
            if (out) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            bits = {bits[30:0], out};
        end
        return bits;
    endfunction

    // Memory contents as a function of the physical address
    function automatic byte_t model_byte(input phys_addr_t p);
        return p[7:0] ^ p[15:8] ^ {4'h0, p[19:16]};
    endfunction

    function automatic phys_addr_t phys_of(input seg_t cs, input offset_t ip);
        return ({4'h0, cs} << 4) + {4'h0, ip};
    endfunction

    // Mid-cycle look at the DUT, consumer check and memory model decision
    task automatic sample_cycle(output logic ack_next, output word_t data_next);
        @(negedge clk);
        // Reads in the flush cycle are dropped by the queue
        if (rd_en && !empty && !flush_cycle) begin
            assert (rd_data == model_byte(phys_of(exp_cs, exp_ip))) else begin
                byte_errors++;
                $display("ERROR: rd_data = %h, expected %h at physical %h", rd_data,
                         model_byte(phys_of(exp_cs, exp_ip)), phys_of(exp_cs, exp_ip));
            end
            exp_ip = exp_ip + 16'd1;
            pops++;
        end
        flush_cycle = load_new_ip;
        if (load_new_ip) begin
            exp_cs = new_cs;
            exp_ip = new_ip;
        end
        ack_next = 1'b0;
        data_next = mem_data;
        access_pending = mem_access && !mem_ack;
        if (mem_ack) begin
            mem_busy = 1'b0;
        end else if (mem_access && !hold_ack) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                wait_left = 2'(take_bits(2));
            end
            if (wait_left == 2'd0) begin
                ack_next = 1'b1;
                data_next = {model_byte({mem_address, 1'b1}), model_byte({mem_address, 1'b0})};
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
    endtask

    task automatic drive_cycle(input logic rd_next, input logic redir, input seg_t cs_next,
                               input offset_t ip_next, input logic ack_next,
                               input word_t data_next);
        @(posedge clk);
        rd_en <= rd_next;
        load_new_ip <= redir;
        new_cs <= cs_next;
        new_ip <= ip_next;
        mem_ack <= ack_next;
        mem_data <= data_next;
    endtask

    task automatic random_phase(input int unsigned target);
        logic    ack_next;
        word_t   data_next;
        logic    rd_next;
        logic    redir;
        seg_t    cs_next;
        offset_t ip_next;
        while (pops < target) begin
            sample_cycle(ack_next, data_next);
            rd_next = (take_bits(2) != 0);
            redir = (take_bits(6) == 0);
            cs_next = new_cs;
            ip_next = new_ip;
            if (redir) begin
                cs_next = 16'(take_bits(16));
                // Half the targets sit just below the IP wrap
                if (take_bits(1) != 0) begin
                    ip_next = {12'hfff, 4'(take_bits(4))};
                end else begin
                    ip_next = 16'(take_bits(16));
                end
            end
            drive_cycle(rd_next, redir, cs_next, ip_next, ack_next, data_next);
        end
    endtask

    // Odd start three bytes before the wrap, read straight through
    task automatic wrap_phase();
        logic  ack_next;
        word_t data_next;
        seg_t  cs_next;
        sample_cycle(ack_next, data_next);
        cs_next = 16'(take_bits(16));
        drive_cycle(1'b0, 1'b1, cs_next, 16'hfffd, ack_next, data_next);
        repeat (40) begin
            sample_cycle(ack_next, data_next);
            drive_cycle(1'b1, 1'b0, new_cs, new_ip, ack_next, data_next);
        end
    endtask

    task automatic redirect_in_flight(input int unsigned count);
        logic    ack_next;
        word_t   data_next;
        seg_t    cs_next;
        offset_t ip_next;
        for (int unsigned n = 0; n < count; n++) begin
            sample_cycle(ack_next, data_next);
            while (!access_pending) begin
                drive_cycle(1'b1, 1'b0, new_cs, new_ip, ack_next, data_next);
                sample_cycle(ack_next, data_next);
            end
            cs_next = 16'(take_bits(16));
            ip_next = {15'(take_bits(15)), n[0]};
            drive_cycle(1'b1, 1'b1, cs_next, ip_next, ack_next, data_next);
            repeat (10) begin
                sample_cycle(ack_next, data_next);
                drive_cycle(1'b1, 1'b0, new_cs, new_ip, ack_next, data_next);
            end
        end
    endtask

    task automatic drain_phase();
        logic        ack_next;
        word_t       data_next;
        int unsigned quiet;
        int unsigned start_pops;
        quiet = 0;
        while (quiet < 16) begin
            sample_cycle(ack_next, data_next);
            quiet = mem_access ? 0 : quiet + 1;
            drive_cycle(1'b0, 1'b0, new_cs, new_ip, ack_next, data_next);
        end
        // Memory held off so only the stalled contents come out
        hold_ack = 1'b1;
        start_pops = pops;
        sample_cycle(ack_next, data_next);
        while (!empty) begin
            drive_cycle(1'b1, 1'b0, new_cs, new_ip, ack_next, data_next);
            sample_cycle(ack_next, data_next);
        end
        hold_ack = 1'b0;
        drive_cycle(1'b0, 1'b0, new_cs, new_ip, ack_next, data_next);
        assert (pops - start_pops <= fifo_depth && pops - start_pops + 1 >= fifo_depth) else begin
            other_errors++;
            $display("Stalled queue gave %0d bytes, depth is %0d", pops - start_pops, fifo_depth);
        end
    endtask

    initial begin : stimulus
        lfsr = 32'hb3be_334e;
        arst_n = 1'b0;
        load_new_ip = 1'b0;
        new_cs = '0;
        new_ip = '0;
        rd_en = 1'b0;
        mem_ack = 1'b0;
        mem_data = '0;
        exp_cs = 16'hffff;
        exp_ip = 16'h0000;
        flush_cycle = 1'b0;
        mem_busy = 1'b0;
        wait_left = '0;
        hold_ack = 1'b0;
        access_pending = 1'b0;
        pops = 0;
        byte_errors = 0;
        other_errors = 0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        random_phase(n_reads);
        wrap_phase();
        redirect_in_flight(8);
        drain_phase();
        random_phase(pops + 100);
        $display("Checked %0d bytes, %0d byte errors, %0d other errors, %0d assertion failures",
                 pops, byte_errors, other_errors, dut_i.chk_i.fail_count);
        if (byte_errors + other_errors + dut_i.chk_i.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(planned_reads * 40 * clk_period);
        $display("Timeout, the run did not finish within %0d cycles", planned_reads * 40);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- tests/prefetch_assertions.sv
// Concurrent bus protocol, reset and queue flag checks, bound into the fetch front end top level
`timescale 1ns/1ps

module prefetch_assertions (
    input logic                clk,
    input logic                arst_n,
    input logic                load_new_ip,
    input logic                rd_en,
    input logic                empty,
    input logic                mem_access,
    input bus_pkg::word_addr_t mem_address,
    input logic                mem_ack,
    input logic                fifo_wr_en,
    input logic                fifo_flush,
    input logic                fifo_nearly_full
);
    import bus_pkg::*;

    // Word holding physical FFFF0
    localparam word_addr_t reset_word = 19'h7_fff8;

    int fail_count = 0;

    reset_state: assert property (@(posedge clk)
        !arst_n |-> !mem_access && empty && !fifo_wr_en && !fifo_flush)
    else begin
        fail_count++;
        $error("Outputs left their reset values while reset was held");
    end

    first_access: assert property (@(posedge clk)
        $rose(arst_n) |=> mem_access && mem_address == reset_word)
    else begin
        fail_count++;
        $error("First access after reset missing or not at the reset address");
    end

    // Address and request held until the ack
    access_held: assert property (@(posedge clk) disable iff (!arst_n)
        mem_access && !mem_ack |=> mem_access && $stable(mem_address))
    else begin
        fail_count++;
        $error("Access dropped or address moved before the ack");
    end

    single_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        mem_access && mem_ack |=> !mem_access)
    else begin
        fail_count++;
        $error("Access still raised in the cycle after its ack");
    end

    flush_empties: assert property (@(posedge clk) disable iff (!arst_n)
        fifo_flush |=> empty)
    else begin
        fail_count++;
        $error("Queue not empty in the cycle after a flush");
    end

    write_shows: assert property (@(posedge clk) disable iff (!arst_n)
        fifo_wr_en && !fifo_flush |=> !empty)
    else begin
        fail_count++;
        $error("Written byte did not reach the queue head");
    end

    // Back-pressure keeps the bus quiet while nobody reads
    stall_holds: assert property (@(posedge clk) disable iff (!arst_n)
        !rd_en && !load_new_ip && !fifo_flush && fifo_nearly_full && !mem_access && !fifo_wr_en
        |=> !mem_access)
    else begin
        fail_count++;
        $error("Fetch started an access into a nearly full queue");
    end

endmodule

bind prefetch_top prefetch_assertions chk_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .load_new_ip      (load_new_ip),
    .rd_en            (rd_en),
    .empty            (empty),
    .mem_access       (mem_access),
    .mem_address      (mem_address),
    .mem_ack          (mem_ack),
    .fifo_wr_en       (fifo_wr_en),
    .fifo_flush       (fifo_flush),
    .fifo_nearly_full (fifo_nearly_full)
);

//--- source/prefetch_top.sv
// Instruction fetch front end top level, fetch unit feeding the byte prefetch queue
`timescale 1ns/1ps

module prefetch_top #(
    parameter int unsigned fifo_depth = prefetch_pkg::DEFAULT_DEPTH
) (
    input  logic                clk,
    input  logic                arst_n,
    // Redirect from the core
    input  logic                load_new_ip,
    input  bus_pkg::seg_t       new_cs,
    input  bus_pkg::offset_t    new_ip,
    // Byte consumer
    input  logic                rd_en,
    output prefetch_pkg::byte_t rd_data,
    output logic                empty,
    // Instruction bus
    output logic                mem_access,
    output bus_pkg::word_addr_t mem_address,
    input  logic                mem_ack,
    input  bus_pkg::word_t      mem_data
);
    import prefetch_pkg::*;

    logic  fifo_wr_en;
    byte_t fifo_wr_data;
    logic  fifo_flush;
    logic  fifo_nearly_full;

    fetch_unit fetch_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .load_new_ip      (load_new_ip),
        .new_cs           (new_cs),
        .new_ip           (new_ip),
        .mem_access       (mem_access),
        .mem_address      (mem_address),
        .mem_ack          (mem_ack),
        .mem_data         (mem_data),
        .fifo_wr_en       (fifo_wr_en),
        .fifo_wr_data     (fifo_wr_data),
        .fifo_flush       (fifo_flush),
        .fifo_nearly_full (fifo_nearly_full)
    );

    prefetch_fifo #(
        .depth (fifo_depth)
    ) fifo_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (fifo_flush),
        .wr_en       (fifo_wr_en),
        .wr_data     (fifo_wr_data),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .empty       (empty),
        .nearly_full (fifo_nearly_full)
    );

endmodule

//--- source/prefetch_fifo.sv
// Byte prefetch queue with fall-through head, single-cycle flush and nearly-full flag
`timescale 1ns/1ps

module prefetch_fifo #(
    parameter int unsigned depth = prefetch_pkg::DEFAULT_DEPTH
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                wr_en,
    input  prefetch_pkg::byte_t wr_data,
    input  logic                rd_en,
    output prefetch_pkg::byte_t rd_data,
    output logic                empty,
    output logic                nearly_full
);
    import prefetch_pkg::*;

    localparam int unsigned ptr_width = $clog2(depth);
    localparam int unsigned cnt_width = $clog2(depth + 1);

    byte_t                mem [depth];
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width-1:0] wr_ptr;
    logic [cnt_width-1:0] count;
    logic [cnt_width:0]   fill_level;
    logic                 do_wr;
    logic                 do_rd;

    // Wrap for depths that are not a power of two
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign rd_data = mem[rd_ptr];

    // Flush beats both ports, reads on an empty queue are dropped
    assign do_wr = wr_en && !flush && (count != cnt_width'(depth));
    assign do_rd = rd_en && !flush && !empty;

    // Includes the byte being written now so the writer sees the space left after it
    assign fill_level = {1'b0, count} + (cnt_width + 1)'(wr_en);
    assign nearly_full = fill_level > (cnt_width + 1)'(depth - WORD_BYTES);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

//--- source/fetch_unit.sv
// Fetch CS:IP, instruction bus access sequencing and word-to-byte unpacking into the queue
`timescale 1ns/1ps

module fetch_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                load_new_ip,
    input  bus_pkg::seg_t       new_cs,
    input  bus_pkg::offset_t    new_ip,
    output logic                mem_access,
    output bus_pkg::word_addr_t mem_address,
    input  logic                mem_ack,
    input  bus_pkg::word_t      mem_data,
    output logic                fifo_wr_en,
    output prefetch_pkg::byte_t fifo_wr_data,
    output logic                fifo_flush,
    input  logic                fifo_nearly_full
);
    import bus_pkg::*;
    import prefetch_pkg::*;

    // FSM encoding
    localparam logic [2:0] s_idle    = 3'd0;
    localparam logic [2:0] s_access  = 3'd1;
    localparam logic [2:0] s_push_lo = 3'd2;
    localparam logic [2:0] s_push_hi = 3'd3;
    localparam logic [2:0] s_discard = 3'd4;

    logic [2:0] state;
    logic [2:0] state_d;
    seg_t       cs;
    seg_t       cs_d;
    offset_t    ip;
    offset_t    ip_d;
    phys_addr_t phys_d;
    word_t      data_q;
    logic       pushing;
    logic       start_access;

    assign pushing = (state == s_push_lo) || (state == s_push_hi);

    // A redirect in the same cycle kills the push, the queue is flushed next cycle anyway
    assign fifo_wr_en = pushing && !load_new_ip;
    assign fifo_wr_data = (state == s_push_lo) ? data_q[7:0] : data_q[15:8];

    // Held through discard so the old access completes cleanly
    assign mem_access = (state == s_access) || (state == s_discard);

    // Next CS:IP, redirect wins over the byte advance
    always_comb begin
        cs_d = cs;
        ip_d = ip;
        if (load_new_ip) begin
            cs_d = new_cs;
            ip_d = new_ip;
        end else if (fifo_wr_en) begin
            // 16-bit wrap, stays inside the segment
            ip_d = ip + 1'b1;
        end
    end

    assign phys_d = (phys_addr_t'(cs_d) << SEG_SHIFT) + phys_addr_t'(ip_d);

    always_comb begin
        state_d = state;
        case (state)
            s_idle: begin
                if (!fifo_nearly_full) begin
                    state_d = s_access;
                end
            end
            s_access: begin
                if (mem_ack) begin
                    if (load_new_ip) begin
                        state_d = s_idle;
                    end else if (ip[0]) begin
                        // Odd IP, only the upper byte belongs to the stream
                        state_d = s_push_hi;
                    end else begin
                        state_d = s_push_lo;
                    end
                end else if (load_new_ip) begin
                    state_d = s_discard;
                end
            end
            s_push_lo: begin
                state_d = load_new_ip ? s_idle : s_push_hi;
            end
            s_push_hi: begin
                // Nearly-full already counts this write
                if (load_new_ip || fifo_nearly_full) begin
                    state_d = s_idle;
                end else begin
                    state_d = s_access;
                end
            end
            s_discard: begin
                if (mem_ack) begin
                    state_d = s_idle;
                end
            end
            default: begin
                state_d = s_idle;
            end
        endcase
    end

    assign start_access = (state_d == s_access) && (state != s_access);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_idle;
            cs <= RESET_CS;
            ip <= RESET_IP;
            fifo_flush <= 1'b0;
        end else begin
            state <= state_d;
            cs <= cs_d;
            ip <= ip_d;
            fifo_flush <= load_new_ip;
        end
    end

    // Address frozen for the whole access, CS:IP may move underneath it
    always_ff @(posedge clk) begin
        if (start_access) begin
            mem_address <= phys_d[PHYS_ADDR_WIDTH-1:1];
        end
    end

    // Word captured on ack and unpacked over the push cycles
    always_ff @(posedge clk) begin
        if (state == s_access && mem_ack) begin
            data_q <= mem_data;
        end
    end

endmodule

//--- source/prefetch_pkg.sv
// Prefetch queue byte type, queue defaults and the reset fetch address
package prefetch_pkg;

    localparam int unsigned BYTE_WIDTH = 8;

    // One instruction byte as held in the queue
    typedef logic [BYTE_WIDTH-1:0] byte_t;

    // Queue depth used unless the top level overrides it
    localparam int unsigned DEFAULT_DEPTH = 6;

    // Fetch starts at FFFF:0000 out of reset, i.e. physical FFFF0
    localparam bus_pkg::seg_t RESET_CS = 16'hffff;
    localparam bus_pkg::offset_t RESET_IP = 16'h0000;

    // Threshold margin, the writer may push a whole bus word
    localparam int unsigned WORD_BYTES = 2;

endpackage

//--- source/bus_pkg.sv
// Instruction bus and address types, shared by the fetch front end and its top level
package bus_pkg;

    // Data word on the instruction bus
    localparam int unsigned WORD_WIDTH = 16;

    // Real-mode address pieces
    localparam int unsigned SEG_WIDTH = 16;
    localparam int unsigned OFFSET_WIDTH = 16;
    localparam int unsigned PHYS_ADDR_WIDTH = 20;
    localparam int unsigned WORD_ADDR_WIDTH = PHYS_ADDR_WIDTH - 1;

    // Physical address is segment shifted by this much plus offset
    localparam int unsigned SEG_SHIFT = 4;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [SEG_WIDTH-1:0] seg_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;
    typedef logic [PHYS_ADDR_WIDTH-1:0] phys_addr_t;

endpackage
